// File: source/krv_periph_pkg.sv
`default_nettype none

package krv_periph_pkg;

	// Bus geometry
	parameter int ADDR_WIDTH = 32;
	parameter int DATA_WIDTH = 32;
	parameter int STRB_WIDTH = DATA_WIDTH / 8;

	// AHB transfer type, HTRANS encoding
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} trans_t;

	// AHB transfer size, HSIZE encoding
	typedef enum logic [2:0] {
		BYTE = 3'b000,
		HALF = 3'b001,
		WORD = 3'b010
	} size_t;

	// Decoded target of a transfer
	typedef enum logic [1:0] {
		REGION_NONE,
		REGION_TCM,
		REGION_TIMER,
		REGION_GPIO
	} region_t;

	// Region bases, selected by the top address byte
	parameter logic [ADDR_WIDTH-1:0] TCM_BASE   = 32'h0000_0000;
	parameter logic [ADDR_WIDTH-1:0] TIMER_BASE = 32'h0200_0000;
	parameter logic [ADDR_WIDTH-1:0] GPIO_BASE  = 32'h1000_0000;

endpackage

`default_nettype wire

// File: source/rst_sync.sv
`timescale 1ns/10ps
`default_nettype none

module rst_sync (
	input  logic hclk,
	input  logic arst_n,
	output logic hresetn
);

	logic rst_meta;
	logic rst_sync_q;

	// Assert at once, release after two hclk edges
	always_ff @(posedge hclk or negedge arst_n) begin
		if (!arst_n) begin
			rst_meta   <= 1'b0;
			rst_sync_q <= 1'b0;
		end else begin
			rst_meta   <= 1'b1;
			rst_sync_q <= rst_meta;
		end
	end

	assign hresetn = rst_sync_q;

endmodule

`default_nettype wire

// File: source/ahb_slave_port.sv
`timescale 1ns/10ps
`default_nettype none

module ahb_slave_port #(
	parameter int TCM_WORDS = 1024,
	localparam int INDEX_WIDTH = $clog2(TCM_WORDS)
) (
	input  logic                                   hclk,
	input  logic                                   hresetn,
	input  krv_periph_pkg::trans_t                 htrans,
	input  logic [krv_periph_pkg::ADDR_WIDTH-1:0]  haddr,
	input  logic                                   hwrite,
	input  krv_periph_pkg::size_t                  hsize,
	input  logic [krv_periph_pkg::DATA_WIDTH-1:0]  hwdata,
	output logic [krv_periph_pkg::DATA_WIDTH-1:0]  hrdata,
	output logic                                   tcm_wr,
	output logic                                   timer_wr,
	output logic                                   gpio_wr,
	output logic [INDEX_WIDTH-1:0]                 word_index,
	output logic [krv_periph_pkg::STRB_WIDTH-1:0]  byte_strb,
	output logic [krv_periph_pkg::DATA_WIDTH-1:0]  wdata,
	input  logic [krv_periph_pkg::DATA_WIDTH-1:0]  tcm_rdata,
	input  logic [krv_periph_pkg::DATA_WIDTH-1:0]  timer_rdata,
	input  logic [krv_periph_pkg::DATA_WIDTH-1:0]  gpio_rdata
);

	import krv_periph_pkg::*;

	localparam logic [ADDR_WIDTH-1:0] TCM_BYTES = ADDR_WIDTH'(TCM_WORDS * 4);

	logic [ADDR_WIDTH-1:0] tcm_offset;
	logic                  xfer_valid;
	region_t               region_d;
	logic [STRB_WIDTH-1:0] strb_d;
	region_t               region_q;
	logic                  write_q;

	assign xfer_valid = (htrans == NONSEQ) || (htrans == SEQ);
	assign tcm_offset = haddr - TCM_BASE;

	// Address phase decode, TCM also bounded by its depth
	always_comb begin
		region_d = REGION_NONE;
		if (xfer_valid) begin
			if (tcm_offset < TCM_BYTES)
				region_d = REGION_TCM;
			else if (haddr[ADDR_WIDTH-1 -: 8] == TIMER_BASE[ADDR_WIDTH-1 -: 8])
				region_d = REGION_TIMER;
			else if (haddr[ADDR_WIDTH-1 -: 8] == GPIO_BASE[ADDR_WIDTH-1 -: 8])
				region_d = REGION_GPIO;
		end
	end

	// Lanes from size and low address bits
	always_comb begin
		case (hsize)
			BYTE:    strb_d = STRB_WIDTH'(1) << haddr[1:0];
			HALF:    strb_d = haddr[1] ? 4'b1100 : 4'b0011;
			default: strb_d = '1;
		endcase
	end

	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn) begin
			region_q <= REGION_NONE;
			write_q  <= 1'b0;
		end else begin
			region_q <= region_d;
			write_q  <= xfer_valid && hwrite;
		end
	end

	// Word index and lanes for the data phase
	always_ff @(posedge hclk) begin
		word_index <= haddr[INDEX_WIDTH+1:2];
		byte_strb  <= strb_d;
	end

	// One pulse per slave, only in the data phase of a write
	assign tcm_wr   = write_q && (region_q == REGION_TCM);
	assign timer_wr = write_q && (region_q == REGION_TIMER);
	assign gpio_wr  = write_q && (region_q == REGION_GPIO);

	assign wdata = hwdata;

	// Unmapped space reads as zero
	always_comb begin
		case (region_q)
			REGION_TCM:   hrdata = tcm_rdata;
			REGION_TIMER: hrdata = timer_rdata;
			REGION_GPIO:  hrdata = gpio_rdata;
			default:      hrdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/dtcm.sv
`timescale 1ns/10ps
`default_nettype none

module dtcm #(
	parameter int TCM_WORDS = 1024,
	localparam int INDEX_WIDTH = $clog2(TCM_WORDS)
) (
	input  logic                                  hclk,
	input  logic                                  tcm_wr,
	input  logic [INDEX_WIDTH-1:0]                word_index,
	input  logic [krv_periph_pkg::STRB_WIDTH-1:0] byte_strb,
	input  logic [krv_periph_pkg::DATA_WIDTH-1:0] wdata,
	output logic [krv_periph_pkg::DATA_WIDTH-1:0] tcm_rdata
);

	import krv_periph_pkg::*;

	logic [DATA_WIDTH-1:0] mem [TCM_WORDS];

	// Byte lane writes at the end of the data phase
	always_ff @(posedge hclk) begin
		for (int lane = 0; lane < STRB_WIDTH; lane++) begin
			if (tcm_wr && byte_strb[lane])
				mem[word_index][lane*8 +: 8] <= wdata[lane*8 +: 8];
		end
	end

	// Read straight from the registered index
	assign tcm_rdata = mem[word_index];

endmodule

`default_nettype wire

// File: source/core_timer.sv
`timescale 1ns/10ps
`default_nettype none

module core_timer (
	input  logic                                  hclk,
	input  logic                                  hresetn,
	input  logic                                  timer_wr,
	input  logic [1:0]                            word_index,
	input  logic [krv_periph_pkg::DATA_WIDTH-1:0] wdata,
	output logic [krv_periph_pkg::DATA_WIDTH-1:0] timer_rdata,
	output logic                                  timer_int
);

	logic [63:0] mtime;
	logic [63:0] mtimecmp;
	logic        wr_time_lo;
	logic        wr_time_hi;
	logic        wr_cmp_lo;
	logic        wr_cmp_hi;

	// Register map 0x0 mtime lo, 0x4 mtime hi, 0x8 cmp lo, 0xC cmp hi
	assign wr_time_lo = timer_wr && (word_index == 2'd0);
	assign wr_time_hi = timer_wr && (word_index == 2'd1);
	assign wr_cmp_lo  = timer_wr && (word_index == 2'd2);
	assign wr_cmp_hi  = timer_wr && (word_index == 2'd3);

	// Free running unless software loads a half
	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn) begin
			mtime <= '0;
		end else if (wr_time_lo) begin
			mtime <= {mtime[63:32], wdata};
		end else if (wr_time_hi) begin
			mtime <= {wdata, mtime[31:0]};
		end else begin
			mtime <= mtime + 64'd1;
		end
	end

	// All ones keeps the interrupt quiet out of reset
	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn) begin
			mtimecmp <= '1;
		end else if (wr_cmp_lo) begin
			mtimecmp[31:0] <= wdata;
		end else if (wr_cmp_hi) begin
			mtimecmp[63:32] <= wdata;
		end
	end

	// Interrupt level, one cycle behind the compare
	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn)
			timer_int <= 1'b0;
		else
			timer_int <= (mtime >= mtimecmp);
	end

	always_comb begin
		case (word_index)
			2'd0:    timer_rdata = mtime[31:0];
			2'd1:    timer_rdata = mtime[63:32];
			2'd2:    timer_rdata = mtimecmp[31:0];
			default: timer_rdata = mtimecmp[63:32];
		endcase
	end

endmodule

`default_nettype wire

// File: source/gpio_regs.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_regs #(
	parameter int GPIO_WIDTH = 8
) (
	input  logic                                  hclk,
	input  logic                                  hresetn,
	input  logic                                  gpio_wr,
	input  logic                                  word_index,
	input  logic [krv_periph_pkg::DATA_WIDTH-1:0] wdata,
	output logic [krv_periph_pkg::DATA_WIDTH-1:0] gpio_rdata,
	input  logic [GPIO_WIDTH-1:0]                 gpio_in,
	output logic [GPIO_WIDTH-1:0]                 gpio_out
);

	import krv_periph_pkg::*;

	logic [GPIO_WIDTH-1:0] gpio_meta;
	logic [GPIO_WIDTH-1:0] gpio_sync;

	// Output register at offset 0x0, the input offset is read only
	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn)
			gpio_out <= '0;
		else if (gpio_wr && !word_index)
			gpio_out <= wdata[GPIO_WIDTH-1:0];
	end

	// Two flop synchronizer on the pins
	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn) begin
			gpio_meta <= '0;
			gpio_sync <= '0;
		end else begin
			gpio_meta <= gpio_in;
			gpio_sync <= gpio_meta;
		end
	end

	assign gpio_rdata = word_index ? DATA_WIDTH'(gpio_sync) : DATA_WIDTH'(gpio_out);

endmodule

`default_nettype wire

// File: source/krv_periph_top.sv
`timescale 1ns/10ps
`default_nettype none

module krv_periph_top #(
	parameter int TCM_WORDS  = 1024,
	parameter int GPIO_WIDTH = 8,
	localparam int INDEX_WIDTH = $clog2(TCM_WORDS)
) (
	input  logic                                  hclk,
	input  logic                                  arst_n,
	input  krv_periph_pkg::trans_t                htrans,
	input  logic [krv_periph_pkg::ADDR_WIDTH-1:0] haddr,
	input  logic                                  hwrite,
	input  krv_periph_pkg::size_t                 hsize,
	input  logic [krv_periph_pkg::DATA_WIDTH-1:0] hwdata,
	output logic [krv_periph_pkg::DATA_WIDTH-1:0] hrdata,
	input  logic [GPIO_WIDTH-1:0]                 gpio_in,
	output logic [GPIO_WIDTH-1:0]                 gpio_out,
	output logic                                  timer_int
);

	import krv_periph_pkg::*;

	logic                   hresetn;
	logic                   tcm_wr;
	logic                   timer_wr;
	logic                   gpio_wr;
	logic [INDEX_WIDTH-1:0] word_index;
	logic [STRB_WIDTH-1:0]  byte_strb;
	logic [DATA_WIDTH-1:0]  wdata;
	logic [DATA_WIDTH-1:0]  tcm_rdata;
	logic [DATA_WIDTH-1:0]  timer_rdata;
	logic [DATA_WIDTH-1:0]  gpio_rdata;

	rst_sync u_rst_sync (
		.hclk    (hclk),
		.arst_n  (arst_n),
		.hresetn (hresetn)
	);

	ahb_slave_port #(
		.TCM_WORDS (TCM_WORDS)
	) u_ahb_slave_port (
		.hclk        (hclk),
		.hresetn     (hresetn),
		.htrans      (htrans),
		.haddr       (haddr),
		.hwrite      (hwrite),
		.hsize       (hsize),
		.hwdata      (hwdata),
		.hrdata      (hrdata),
		.tcm_wr      (tcm_wr),
		.timer_wr    (timer_wr),
		.gpio_wr     (gpio_wr),
		.word_index  (word_index),
		.byte_strb   (byte_strb),
		.wdata       (wdata),
		.tcm_rdata   (tcm_rdata),
		.timer_rdata (timer_rdata),
		.gpio_rdata  (gpio_rdata)
	);

	dtcm #(
		.TCM_WORDS (TCM_WORDS)
	) u_dtcm (
		.hclk       (hclk),
		.tcm_wr     (tcm_wr),
		.word_index (word_index),
		.byte_strb  (byte_strb),
		.wdata      (wdata),
		.tcm_rdata  (tcm_rdata)
	);

	// Timer and GPIO only decode the low index bits
	core_timer u_core_timer (
		.hclk        (hclk),
		.hresetn     (hresetn),
		.timer_wr    (timer_wr),
		.word_index  (word_index[1:0]),
		.wdata       (wdata),
		.timer_rdata (timer_rdata),
		.timer_int   (timer_int)
	);

	gpio_regs #(
		.GPIO_WIDTH (GPIO_WIDTH)
	) u_gpio_regs (
		.hclk       (hclk),
		.hresetn    (hresetn),
		.gpio_wr    (gpio_wr),
		.word_index (word_index[0]),
		.wdata      (wdata),
		.gpio_rdata (gpio_rdata),
		.gpio_in    (gpio_in),
		.gpio_out   (gpio_out)
	);

endmodule

`default_nettype wire

// File: tests/tb_krv_periph.sv
`timescale 1ns/10ps
`default_nettype none

module tb_krv_periph;

	import krv_periph_pkg::*;

	localparam int TCM_WORDS      = 1024;
	localparam int GPIO_WIDTH     = 8;
	localparam int TIMEOUT_CYCLES = 5000;
	localparam logic [31:0] SEED  = 32'h3d3237d0;

	// Register offsets within each region
	localparam logic [31:0] MTIME_LO    = TIMER_BASE + 32'h0;
	localparam logic [31:0] MTIME_HI    = TIMER_BASE + 32'h4;
	localparam logic [31:0] MTIMECMP_LO = TIMER_BASE + 32'h8;
	localparam logic [31:0] MTIMECMP_HI = TIMER_BASE + 32'hc;
	localparam logic [31:0] GPIO_OUT    = GPIO_BASE + 32'h0;
	localparam logic [31:0] GPIO_IN     = GPIO_BASE + 32'h4;
	localparam logic [31:0] GPIO_MASK   = (32'd1 << GPIO_WIDTH) - 32'd1;
	localparam logic [31:0] UNMAPPED    = 32'h2000_0000;

	logic                  hclk;
	logic                  arst_n;
	trans_t                htrans;
	logic [31:0]           haddr;
	logic                  hwrite;
	size_t                 hsize;
	logic [31:0]           hwdata;
	logic [31:0]           hrdata;
	logic [GPIO_WIDTH-1:0] gpio_in;
	logic [GPIO_WIDTH-1:0] gpio_out;
	logic                  timer_int;

	krv_periph_top #(
		.TCM_WORDS  (TCM_WORDS),
		.GPIO_WIDTH (GPIO_WIDTH)
	) i_krv_periph_top (
		.hclk      (hclk),
		.arst_n    (arst_n),
		.htrans    (htrans),
		.haddr     (haddr),
		.hwrite    (hwrite),
		.hsize     (hsize),
		.hwdata    (hwdata),
		.hrdata    (hrdata),
		.gpio_in   (gpio_in),
		.gpio_out  (gpio_out),
		.timer_int (timer_int)
	);

	initial begin
		hclk = 1'b0;
		forever #5 hclk = ~hclk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "run stopped at the first error");
	endtask

	// More than twenty times the cycles the directed tests need
	initial begin
		int cycle_count;
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge hclk);
			cycle_count++;
		end
		abort_run($sformatf("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES));
	end

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else abort_run($sformatf("[FAIL] %0t: %s got 0x%08h expected 0x%08h",
			$time, what, got, exp));
	endtask

	// Address phase for one cycle and write data in the next
	task automatic ahb_write(input logic [31:0] addr, input size_t xfer_size,
			input logic [31:0] data);
		@(posedge hclk);
		#1;
		htrans = NONSEQ;
		haddr  = addr;
		hwrite = 1'b1;
		hsize  = xfer_size;
		@(posedge hclk);
		#1;
		htrans = IDLE;
		hwrite = 1'b0;
		hwdata = data;
	endtask

	task automatic fetch_word(input logic [31:0] addr, output logic [31:0] got);
		@(posedge hclk);
		#1;
		htrans = NONSEQ;
		haddr  = addr;
		hwrite = 1'b0;
		hsize  = WORD;
		@(posedge hclk);
		#1;
		htrans = IDLE;
		got    = hrdata;
	endtask

	task automatic ahb_read(input logic [31:0] addr, input logic [31:0] exp);
		logic [31:0] got;
		fetch_word(addr, got);
		check_value($sformatf("read 0x%08h", addr), got, exp);
	endtask

	// Read address phase overlaps the write data phase
	task automatic write_then_read(input logic [31:0] addr, input logic [31:0] data);
		@(posedge hclk);
		#1;
		htrans = NONSEQ;
		haddr  = addr;
		hwrite = 1'b1;
		hsize  = WORD;
		@(posedge hclk);
		#1;
		hwrite = 1'b0;
		hwdata = data;
		@(posedge hclk);
		#1;
		htrans = IDLE;
		check_value($sformatf("back-to-back read 0x%08h", addr), hrdata, data);
	endtask

	// Reference word with lanes first_lane to first_lane+nbytes-1 replaced
	function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
			input logic [31:0] bus_data, input int first_lane, input int nbytes);
		logic [31:0] result;
		result = old_word;
		for (int lane = 0; lane < 4; lane++) begin
			if (lane >= first_lane && lane < first_lane + nbytes)
				result[lane*8 +: 8] = bus_data[lane*8 +: 8];
		end
		return result;
	endfunction

	task automatic reset_state_test();
		check_value("gpio_out after reset", 32'(gpio_out), 32'h0);
		check_value("timer_int after reset", 32'(timer_int), 32'h0);
		ahb_read(MTIMECMP_HI, 32'hffff_ffff);
		ahb_read(MTIMECMP_LO, 32'hffff_ffff);
	endtask

	task automatic tcm_word_test();
		int unsigned idx_list [16];
		logic [31:0] data_list [16];
		logic [31:0] fresh;
		// One index per 64-word slice keeps them distinct
		for (int i = 0; i < 16; i++) begin
			idx_list[i]  = i * 64 + $urandom_range(63, 0);
			data_list[i] = $urandom;
			ahb_write(TCM_BASE + (idx_list[i] << 2), WORD, data_list[i]);
		end
		for (int i = 0; i < 16; i++)
			ahb_read(TCM_BASE + (idx_list[i] << 2), data_list[i]);
		fresh = $urandom;
		write_then_read(TCM_BASE + 32'h0000_0ffc, fresh);
		fresh = $urandom;
		write_then_read(TCM_BASE + (idx_list[3] << 2), fresh);
	endtask

	task automatic write_partial(input logic [31:0] addr, input size_t xfer_size,
			input logic [31:0] value, inout logic [31:0] ref_word);
		int first_lane;
		int nbytes;
		logic [31:0] lane_data;
		first_lane = int'(addr[1:0]);
		nbytes     = (xfer_size == BYTE) ? 1 : (xfer_size == HALF) ? 2 : 4;
		lane_data  = value << (8 * first_lane);
		ahb_write(addr, xfer_size, lane_data);
		ref_word = merge_lanes(ref_word, lane_data, first_lane, nbytes);
	endtask

	task automatic tcm_byte_test();
		logic [31:0] base;
		logic [31:0] ref_word;
		base     = TCM_BASE + 32'h0000_0200;
		ref_word = $urandom;
		ahb_write(base, WORD, ref_word);
		write_partial(base + 32'd1, BYTE, 32'h0000_005a, ref_word);
		write_partial(base + 32'd3, BYTE, 32'h0000_00c3, ref_word);
		ahb_read(base, ref_word);
		write_partial(base + 32'd2, HALF, 32'h0000_beef, ref_word);
		write_partial(base + 32'd0, BYTE, $urandom & 32'hff, ref_word);
		ahb_read(base, ref_word);
		write_partial(base + 32'd0, HALF, $urandom & 32'hffff, ref_word);
		write_partial(base + 32'd2, BYTE, $urandom & 32'hff, ref_word);
		ahb_read(base, ref_word);
	endtask

	task automatic gpio_test();
		logic [31:0] out_val;
		logic [31:0] tcm_word;
		logic [GPIO_WIDTH-1:0] pins;
		out_val = $urandom;
		ahb_write(GPIO_OUT, WORD, out_val);
		ahb_read(GPIO_OUT, out_val & GPIO_MASK);
		check_value("gpio_out pins", 32'(gpio_out), out_val & GPIO_MASK);

		// Two-flop synchronizer on the input pins
		pins = GPIO_WIDTH'($urandom);
		@(posedge hclk);
		#1;
		gpio_in = pins;
		repeat (3) @(posedge hclk);
		ahb_read(GPIO_IN, 32'(pins));
		ahb_write(GPIO_IN, WORD, ~32'(pins));
		ahb_read(GPIO_IN, 32'(pins));
		ahb_read(GPIO_OUT, out_val & GPIO_MASK);

		// Just past the TCM would alias index 0 if decoded wrongly
		tcm_word = $urandom;
		ahb_write(TCM_BASE, WORD, tcm_word);
		ahb_write(TCM_BASE + 32'h0000_1000, WORD, ~tcm_word);
		ahb_write(UNMAPPED, WORD, $urandom);
		ahb_read(TCM_BASE + 32'h0000_1000, 32'h0);
		ahb_read(UNMAPPED, 32'h0);
		ahb_read(TCM_BASE, tcm_word);
		check_value("gpio_out after unmapped write", 32'(gpio_out), out_val & GPIO_MASK);
	endtask

	task automatic wait_for_int(input logic level, input int max_cycles, input string what);
		int waited;
		waited = 0;
		while (timer_int !== level && waited < max_cycles) begin
			@(posedge hclk);
			#1;
			waited++;
		end
		assert (timer_int === level)
		else abort_run($sformatf("[FAIL] %0t: %s", $time, what));
	endtask

	task automatic timer_test();
		logic [31:0] t0;
		logic [31:0] now;
		t0 = 32'h0010_0000 + ($urandom & 32'h0000_ffff);
		ahb_write(MTIME_HI, WORD, 32'h0);
		ahb_write(MTIME_LO, WORD, t0);
		fetch_word(MTIME_LO, now);
		assert (now >= t0 && now <= t0 + 32'd20)
		else abort_run($sformatf("[FAIL] %0t: mtime 0x%08h outside 0x%08h plus 20",
			$time, now, t0));
		ahb_read(MTIME_HI, 32'h0);

		ahb_write(MTIMECMP_HI, WORD, 32'h0);
		fetch_word(MTIME_LO, now);
		ahb_write(MTIMECMP_LO, WORD, now + 32'd50);
		repeat (40) begin
			@(posedge hclk);
			#1;
			assert (timer_int === 1'b0)
			else abort_run($sformatf("[FAIL] %0t: timer_int rose before mtimecmp", $time));
		end
		wait_for_int(1'b1, 20, "timer_int not raised within 60 cycles");

		ahb_write(MTIMECMP_LO, WORD, 32'hffff_ffff);
		ahb_write(MTIMECMP_HI, WORD, 32'hffff_ffff);
		wait_for_int(1'b0, 5, "timer_int still high after mtimecmp set to all ones");
		ahb_read(MTIMECMP_HI, 32'hffff_ffff);
	endtask

	initial begin
		arst_n  = 1'b0;
		htrans  = IDLE;
		haddr   = 32'h0;
		hwrite  = 1'b0;
		hsize   = WORD;
		hwdata  = 32'h0;
		gpio_in = '0;
		void'($urandom(SEED));

		repeat (16) @(posedge hclk);
		#1;
		arst_n = 1'b1;
		// Internal reset releases two edges later
		repeat (3) @(posedge hclk);
		#1;

		reset_state_test();
		tcm_word_test();
		tcm_byte_test();
		gpio_test();
		timer_test();

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
source/krv_periph_pkg.sv
source/rst_sync.sv
source/ahb_slave_port.sv
source/dtcm.sv
source/core_timer.sv
source/gpio_regs.sv
source/krv_periph_top.sv
tests/tb_krv_periph.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_krv_periph \
	-f compile.f

./obj_dir/Vtb_krv_periph
